//--- source/adma_pkg.sv
////////////////////////////////////////////////////////////
// adma package
// shared types and constants of the ADMA2 descriptor engine
////////////////////////////////////////////////////////////

package adma_pkg;

	////////////////////////////////////////////////////////////
	// data types
	////////////////////////////////////////////////////////////

	typedef logic [63:0] sys_addr_t;   // system memory byte address
	typedef logic [31:0] mem_word_t;   // one memory data word
	typedef logic [95:0] descriptor_t; // attribute word plus 64-bit address
	typedef logic [15:0] length_t;     // byte length, multiple of 4

	// action field of the attribute word, 01 decodes as nop too
	typedef enum logic [1:0] {
		ACT_NOP  = 2'b00,
		ACT_TRAN = 2'b10,
		ACT_LINK = 2'b11
	} adma_act_t;

	////////////////////////////////////////////////////////////
	// attribute word layout
	////////////////////////////////////////////////////////////

	parameter int ATTR_VALID   = 0;
	parameter int ATTR_END     = 1;
	parameter int ATTR_INT     = 2;  // kept in the format, no interrupts here
	parameter int ATTR_ACT_LSB = 4;  // action in bits 5:4
	parameter int ATTR_LEN_LSB = 16; // length in bits 31:16

	// descriptor slices
	parameter int DESC_ATTR_LSB = 0;
	parameter int DESC_ADDR_LSB = 32;

	////////////////////////////////////////////////////////////
	// address steps
	////////////////////////////////////////////////////////////

	parameter int DESC_BYTES = 12; // three words per descriptor
	parameter int WORD_BYTES = 4;

endpackage

//--- source/descriptor_fetch.sv
////////////////////////////////////////////////////////////
// descriptor fetch
// reads the three words of one descriptor from system
// memory and assembles them into a 96-bit descriptor
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module descriptor_fetch (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  logic                   desc_start,
	input  adma_pkg::sys_addr_t    desc_ptr,
	input  adma_pkg::mem_word_t    ram_rdata,
	output adma_pkg::sys_addr_t    fetch_addr,
	output adma_pkg::descriptor_t  descriptor,
	output logic                   fetch_done
);

	// one-hot states
	typedef enum logic [3:0] {
		WAIT      = 4'b0001,
		FST_FETCH = 4'b0010,
		SND_FETCH = 4'b0100,
		TRD_FETCH = 4'b1000
	} fetch_state_t;

	fetch_state_t state;
	fetch_state_t next_state;
	adma_pkg::descriptor_t desc_q;

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= WAIT;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			WAIT:      next_state = desc_start ? FST_FETCH : WAIT;
			FST_FETCH: next_state = SND_FETCH;
			SND_FETCH: next_state = TRD_FETCH;
			TRD_FETCH: next_state = WAIT;
			default:   next_state = WAIT;
		endcase
	end

	// address of the word that returns in the next state
	always_comb begin
		case (state)
			FST_FETCH: fetch_addr = desc_ptr + adma_pkg::sys_addr_t'(adma_pkg::WORD_BYTES);
			SND_FETCH: fetch_addr = desc_ptr + adma_pkg::sys_addr_t'(2 * adma_pkg::WORD_BYTES);
			default:   fetch_addr = desc_ptr; // first word goes out while waiting
		endcase
	end

	////////////////////////////////////////////////////////////
	// descriptor capture
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		case (state)
			FST_FETCH: desc_q[31:0]  <= ram_rdata; // attribute word
			SND_FETCH: desc_q[63:32] <= ram_rdata; // address low
			TRD_FETCH: desc_q[95:64] <= ram_rdata; // address high
			default:   desc_q        <= desc_q;
		endcase
	end

	// done one cycle after the last capture
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			fetch_done <= 1'b0;
		end else begin
			fetch_done <= (state == TRD_FETCH);
		end
	end

	assign descriptor = desc_q;

endmodule

//--- source/transfer_engine.sv
////////////////////////////////////////////////////////////
// transfer engine
// streams a run of 32-bit words from system memory out as
// data_valid pulses, one address in flight at a time
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module transfer_engine (
	input  logic                 CLK,
	input  logic                 rst_n,
	input  logic                 xfer_start,
	input  adma_pkg::sys_addr_t  xfer_base,
	input  adma_pkg::length_t    xfer_words,
	input  adma_pkg::mem_word_t  ram_rdata,
	output adma_pkg::sys_addr_t  xfer_addr,
	output adma_pkg::mem_word_t  data_out,
	output logic                 data_valid,
	output logic                 xfer_last
);

	adma_pkg::sys_addr_t addr_q;  // next address to issue
	adma_pkg::length_t   remain;  // words still to issue
	logic                issue;   // an address goes out this cycle
	logic                valid_q; // word for last cycle's address arrives now
	logic                last_q;

	// first address leaves with the start pulse itself
	assign xfer_addr = xfer_start ? xfer_base : addr_q;
	assign issue     = xfer_start ? (xfer_words != '0) : (remain != '0);

	////////////////////////////////////////////////////////////
	// address and word counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (issue) begin
			addr_q <= xfer_addr + adma_pkg::sys_addr_t'(adma_pkg::WORD_BYTES);
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			remain <= '0;
		end else if (xfer_start) begin
			// the start cycle issues one word already
			remain <= (xfer_words != '0) ? xfer_words - 1'b1 : '0;
		end else if (remain != '0) begin
			remain <= remain - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// delayed valid, memory latency is one cycle
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			last_q  <= 1'b0;
		end else if (xfer_start) begin
			valid_q <= (xfer_words != '0);
			last_q  <= (xfer_words == 16'd1);
		end else begin
			valid_q <= (remain != '0);
			last_q  <= (remain == 16'd1); // final address goes out now
		end
	end

	assign data_valid = valid_q;
	assign xfer_last  = last_q;
	assign data_out   = valid_q ? ram_rdata : '0; // quiet bus between words

endmodule

//--- source/adma_controller.sv
////////////////////////////////////////////////////////////
// adma controller
// walks the descriptor table, decodes each attribute word,
// owns the memory address mux and drives the status pulses
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module adma_controller (
	input  logic                   CLK,
	input  logic                   rst_n,
	input  logic                   start,
	input  adma_pkg::sys_addr_t    desc_base,
	input  adma_pkg::descriptor_t  descriptor,
	input  logic                   fetch_done,
	input  adma_pkg::sys_addr_t    fetch_addr,
	input  adma_pkg::sys_addr_t    xfer_addr,
	input  logic                   xfer_last,
	output logic                   desc_start,
	output adma_pkg::sys_addr_t    desc_ptr,
	output logic                   xfer_start,
	output adma_pkg::sys_addr_t    xfer_base,
	output adma_pkg::length_t      xfer_words,
	output adma_pkg::sys_addr_t    ram_addr,
	output logic                   busy,
	output logic                   xfer_done,
	output logic                   adma_error
);

	typedef enum logic [1:0] {
		ST_STOP,
		ST_FDS,
		ST_CADR,
		ST_TFR
	} adma_state_t;

	adma_state_t         state;
	adma_pkg::mem_word_t attr;
	adma_pkg::adma_act_t act;
	adma_pkg::length_t   len;
	adma_pkg::sys_addr_t desc_addr;
	logic                attr_valid;
	logic                attr_end;

	////////////////////////////////////////////////////////////
	// attribute decode
	////////////////////////////////////////////////////////////

	assign attr       = descriptor[adma_pkg::DESC_ATTR_LSB +: 32];
	assign desc_addr  = descriptor[adma_pkg::DESC_ADDR_LSB +: 64];
	assign attr_valid = attr[adma_pkg::ATTR_VALID];
	assign attr_end   = attr[adma_pkg::ATTR_END];
	assign act        = adma_pkg::adma_act_t'(attr[adma_pkg::ATTR_ACT_LSB +: 2]);
	assign len        = attr[adma_pkg::ATTR_LEN_LSB +: 16];

	// memory belongs to the transfer engine only while transferring
	assign ram_addr = (state == ST_TFR) ? xfer_addr : fetch_addr;

	// stays up through the final status pulse
	assign busy = (state != ST_STOP) | xfer_done | adma_error;

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state      <= ST_STOP;
			desc_ptr   <= '0;
			desc_start <= 1'b0;
			xfer_start <= 1'b0;
			xfer_done  <= 1'b0;
			adma_error <= 1'b0;
		end else begin
			// pulses by default
			desc_start <= 1'b0;
			xfer_start <= 1'b0;
			xfer_done  <= 1'b0;
			adma_error <= 1'b0;

			case (state)
				ST_STOP: begin
					if (start && !busy) begin
						desc_ptr   <= desc_base;
						desc_start <= 1'b1;
						state      <= ST_FDS;
					end
				end

				ST_FDS: begin
					if (fetch_done) begin
						state <= ST_CADR;
					end
				end

				ST_CADR: begin
					if (!attr_valid) begin
						adma_error <= 1'b1;
						state      <= ST_STOP;
					end else if (act == adma_pkg::ACT_TRAN && len != '0) begin
						xfer_start <= 1'b1;
						state      <= ST_TFR;
					end else if (attr_end) begin
						xfer_done <= 1'b1; // link with end stops here, no jump
						state     <= ST_STOP;
					end else begin
						if (act == adma_pkg::ACT_LINK) begin
							desc_ptr <= desc_addr;
						end else begin
							desc_ptr <= desc_ptr
								+ adma_pkg::sys_addr_t'(adma_pkg::DESC_BYTES);
						end
						desc_start <= 1'b1;
						state      <= ST_FDS;
					end
				end

				ST_TFR: begin
					if (xfer_last) begin
						if (attr_end) begin
							xfer_done <= 1'b1;
							state     <= ST_STOP;
						end else begin
							desc_ptr   <= desc_ptr
								+ adma_pkg::sys_addr_t'(adma_pkg::DESC_BYTES);
							desc_start <= 1'b1;
							state      <= ST_FDS;
						end
					end
				end

				default: state <= ST_STOP;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// transfer parameters, loaded with xfer_start
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (state == ST_CADR) begin
			xfer_base  <= desc_addr;
			xfer_words <= len >> 2; // bytes to words
		end
	end

endmodule

//--- source/adma_top.sv
////////////////////////////////////////////////////////////
// adma top
// descriptor engine with a single system memory read port
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module adma_top (
	input  logic                 CLK,
	input  logic                 rst_n,
	input  logic                 start,
	input  adma_pkg::sys_addr_t  desc_base,
	output adma_pkg::sys_addr_t  ram_addr,
	input  adma_pkg::mem_word_t  ram_rdata,
	output adma_pkg::mem_word_t  data_out,
	output logic                 data_valid,
	output logic                 busy,
	output logic                 xfer_done,
	output logic                 adma_error
);

	// controller to fetch
	logic                  desc_start;
	adma_pkg::sys_addr_t   desc_ptr;
	adma_pkg::sys_addr_t   fetch_addr;
	adma_pkg::descriptor_t descriptor;
	logic                  fetch_done;

	// controller to transfer engine
	logic                  xfer_start;
	adma_pkg::sys_addr_t   xfer_base;
	adma_pkg::length_t     xfer_words;
	adma_pkg::sys_addr_t   xfer_addr;
	logic                  xfer_last;

	adma_controller u_ctrl (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.start      (start),
		.desc_base  (desc_base),
		.descriptor (descriptor),
		.fetch_done (fetch_done),
		.fetch_addr (fetch_addr),
		.xfer_addr  (xfer_addr),
		.xfer_last  (xfer_last),
		.desc_start (desc_start),
		.desc_ptr   (desc_ptr),
		.xfer_start (xfer_start),
		.xfer_base  (xfer_base),
		.xfer_words (xfer_words),
		.ram_addr   (ram_addr),
		.busy       (busy),
		.xfer_done  (xfer_done),
		.adma_error (adma_error)
	);

	descriptor_fetch u_fetch (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.desc_start (desc_start),
		.desc_ptr   (desc_ptr),
		.ram_rdata  (ram_rdata),
		.fetch_addr (fetch_addr),
		.descriptor (descriptor),
		.fetch_done (fetch_done)
	);

	transfer_engine u_xfer (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.xfer_start (xfer_start),
		.xfer_base  (xfer_base),
		.xfer_words (xfer_words),
		.ram_rdata  (ram_rdata),
		.xfer_addr  (xfer_addr),
		.data_out   (data_out),
		.data_valid (data_valid),
		.xfer_last  (xfer_last)
	);

endmodule

//--- tests/adma_checker.sv
////////////////////////////////////////////////////////////
// adma protocol checker
// concurrent assertions on the top-level status pulses and
// the three-word fetch pattern on the memory address
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module adma_checker (
	input logic                 CLK,
	input logic                 rst_n,
	input logic                 start,
	input adma_pkg::sys_addr_t  desc_base,
	input adma_pkg::sys_addr_t  ram_addr,
	input logic                 desc_start,
	input adma_pkg::sys_addr_t  desc_ptr,
	input logic                 data_valid,
	input logic                 busy,
	input logic                 xfer_done,
	input logic                 adma_error
);

	int unsigned fail_count = 0; // assertion failures so far
	logic        accept;

	assign accept = start && !busy; // start that the controller takes

	////////////////////////////////////////////////////////////
	// status pulses
	////////////////////////////////////////////////////////////

	a_valid_busy: assert property (@(posedge CLK) disable iff (!rst_n)
		data_valid |-> busy)
		else begin $error("data_valid while not busy"); fail_count++; end

	a_done_error: assert property (@(posedge CLK) disable iff (!rst_n)
		!(xfer_done && adma_error))
		else begin $error("xfer_done and adma_error together"); fail_count++; end

	// a pulse only ends a run that was already busy
	a_pulse_busy: assert property (@(posedge CLK) disable iff (!rst_n)
		(xfer_done || adma_error) |-> $past(busy))
		else begin $error("status pulse outside busy"); fail_count++; end

	a_busy_falls: assert property (@(posedge CLK) disable iff (!rst_n)
		(xfer_done || adma_error) |=> !busy)
		else begin $error("busy still high after the final pulse"); fail_count++; end

	////////////////////////////////////////////////////////////
	// fetch pattern, first descriptor after start
	////////////////////////////////////////////////////////////

	a_start_word0: assert property (@(posedge CLK) disable iff (!rst_n)
		accept |=> ram_addr == $past(desc_base))
		else begin $error("first fetch address is not desc_base"); fail_count++; end

	a_start_word1: assert property (@(posedge CLK) disable iff (!rst_n)
		$past(accept, 2) |-> ram_addr == $past(desc_base, 2) + 64'd4)
		else begin $error("second fetch address is not desc_base+4"); fail_count++; end

	a_start_word2: assert property (@(posedge CLK) disable iff (!rst_n)
		$past(accept, 3) |-> ram_addr == $past(desc_base, 3) + 64'd8)
		else begin $error("third fetch address is not desc_base+8"); fail_count++; end

	// every later fetch walks its own pointer the same way
	a_fetch_step: assert property (@(posedge CLK) disable iff (!rst_n)
		$past(desc_start, 2) |-> ram_addr == desc_ptr + 64'd8)
		else begin $error("descriptor fetch skipped a word"); fail_count++; end

endmodule

bind adma_top adma_checker u_check (
	.CLK        (CLK),
	.rst_n      (rst_n),
	.start      (start),
	.desc_base  (desc_base),
	.ram_addr   (ram_addr),
	.desc_start (desc_start),
	.desc_ptr   (desc_ptr),
	.data_valid (data_valid),
	.busy       (busy),
	.xfer_done  (xfer_done),
	.adma_error (adma_error)
);

//--- tests/adma_tb.sv
////////////////////////////////////////////////////////////
// adma testbench
// memory model, random descriptor tables and a scoreboard
// for the streamed words and the final status pulse
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module adma_tb;

	localparam int          TIMEOUT   = 2000; // cycles per wait
	localparam logic [15:0] LFSR_SEED = 16'd88;
	localparam logic [15:0] LFSR_TAPS = 16'hB400;

	logic                 CLK;
	logic                 rst_n;
	logic                 start;
	adma_pkg::sys_addr_t  desc_base;
	adma_pkg::sys_addr_t  ram_addr;
	adma_pkg::mem_word_t  ram_rdata = '0;
	adma_pkg::mem_word_t  data_out;
	logic                 data_valid;
	logic                 busy;
	logic                 xfer_done;
	logic                 adma_error;

	adma_pkg::mem_word_t  mem [adma_pkg::sys_addr_t]; // sparse system memory
	adma_pkg::sys_addr_t  read_addr_q = '0;
	adma_pkg::mem_word_t  exp_words [$];
	int                   done_count;
	int                   error_count;
	logic [15:0]          lfsr_state = LFSR_SEED;

	adma_top dut (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.start      (start),
		.desc_base  (desc_base),
		.ram_addr   (ram_addr),
		.ram_rdata  (ram_rdata),
		.data_out   (data_out),
		.data_valid (data_valid),
		.busy       (busy),
		.xfer_done  (xfer_done),
		.adma_error (adma_error)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("TB FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp)
			else stop_on_error($sformatf("Fail at %0d ns: %s = %h, expected %h",
				$time, name, got, exp));
	endtask

	////////////////////////////////////////////////////////////
	// random values and memory
	////////////////////////////////////////////////////////////

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ LFSR_TAPS;
		return n;
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r          = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic adma_pkg::mem_word_t mem_read(input adma_pkg::sys_addr_t a);
		if (mem.exists(a))
			return mem[a];
		return a[31:0] ^ a[63:32] ^ 32'h6c3a_91e5; // unwritten words
	endfunction

	// word for last cycle's address, stable before the next rising edge
	always @(posedge CLK) read_addr_q <= ram_addr;
	always @(negedge CLK) ram_rdata <= mem_read(read_addr_q);

	////////////////////////////////////////////////////////////
	// table building
	////////////////////////////////////////////////////////////

	function automatic adma_pkg::mem_word_t make_attr(input logic valid, input logic last,
		input logic [1:0] act, input int words);
		adma_pkg::mem_word_t a;
		a = '0;
		a[adma_pkg::ATTR_VALID] = valid;
		a[adma_pkg::ATTR_END]   = last;
		a[adma_pkg::ATTR_ACT_LSB +: 2] = act;
		a[adma_pkg::ATTR_LEN_LSB +: 16] = 16'(words * adma_pkg::WORD_BYTES);
		return a;
	endfunction

	task automatic put_desc(input adma_pkg::sys_addr_t at, input adma_pkg::mem_word_t attr,
		input adma_pkg::sys_addr_t target);
		mem[at]         = attr;
		mem[at + 64'd4] = target[31:0]; // low word first
		mem[at + 64'd8] = target[63:32];
	endtask

	// random data block, recorded in stream order
	task automatic fill_data(input adma_pkg::sys_addr_t base, input int words);
		adma_pkg::mem_word_t w;
		for (int i = 0; i < words; i++) begin
			w = rand_bits(32);
			mem[base + 64'(i * adma_pkg::WORD_BYTES)] = w;
			exp_words.push_back(w);
		end
	endtask

	function automatic int rand_len();
		return int'(rand_bits(4)) + 1; // 1 to 16 words
	endfunction

	////////////////////////////////////////////////////////////
	// scoreboard
	////////////////////////////////////////////////////////////

	always @(posedge CLK) begin
		if (rst_n) begin
			if (data_valid) begin
				assert (exp_words.size() != 0)
					else stop_on_error("data word arrived with none expected");
				check_value("data_out", data_out, exp_words.pop_front());
			end
			if (xfer_done)
				done_count++;
			if (adma_error)
				error_count++;
		end
	end

	always @(negedge CLK) begin
		if (dut.u_check.fail_count != 0)
			stop_on_error("a bound protocol assertion failed");
	end

	task automatic run_table(input adma_pkg::sys_addr_t base, input int exp_done,
		input int exp_error, input bit extra, input adma_pkg::sys_addr_t extra_base);
		int cycles;
		done_count  = 0;
		error_count = 0;
		check_value("busy before start", busy, 1'b0);
		start     = 1'b1;
		desc_base = base;
		@(negedge CLK);
		start = 1'b0;
		cycles = 0;
		while (!(xfer_done || adma_error)) begin
			@(negedge CLK);
			cycles++;
			if (cycles > TIMEOUT)
				stop_on_error("timeout waiting for xfer_done or adma_error");
		end
		if (extra) begin
			start     = 1'b1; // lands in the final pulse cycle, busy still high
			desc_base = extra_base;
			@(negedge CLK);
			start = 1'b0;
		end
		cycles = 0;
		while (busy) begin
			@(negedge CLK);
			cycles++;
			if (cycles > TIMEOUT)
				stop_on_error("timeout waiting for busy to fall");
		end
		check_value("xfer_done count", done_count, exp_done);
		check_value("adma_error count", error_count, exp_error);
		check_value("words not streamed", exp_words.size(), 0);
		@(negedge CLK);
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int w;
		rst_n     = 1'b0;
		start     = 1'b0;
		desc_base = '0;
		repeat (16) @(negedge CLK);
		rst_n = 1'b1;
		@(negedge CLK);
		check_value("busy", busy, 1'b0);
		check_value("data_valid", data_valid, 1'b0);
		check_value("xfer_done", xfer_done, 1'b0);
		check_value("adma_error", adma_error, 1'b0);

		// one tran with end, data above 4 GB
		w = rand_len();
		put_desc(64'h1000, make_attr(1'b1, 1'b1, adma_pkg::ACT_TRAN, w), 64'h1_0000_2000);
		fill_data(64'h1_0000_2000, w);
		run_table(64'h1000, 1, 0, 1'b0, '0);

		// nop, tran, link to a second table, tran with end
		put_desc(64'h3000, make_attr(1'b1, 1'b0, 2'b01, 3), 64'hdead_0000); // 01 is a nop
		w = rand_len();
		put_desc(64'h300c, make_attr(1'b1, 1'b0, adma_pkg::ACT_TRAN, w), 64'h4000);
		fill_data(64'h4000, w);
		put_desc(64'h3018, make_attr(1'b1, 1'b0, adma_pkg::ACT_LINK, 0), 64'h2_0000_5000);
		w = rand_len();
		put_desc(64'h2_0000_5000, make_attr(1'b1, 1'b1, adma_pkg::ACT_TRAN, w), 64'h6000);
		fill_data(64'h6000, w);
		run_table(64'h3000, 1, 0, 1'b0, '0);

		// good tran, then a descriptor without the valid bit
		w = rand_len();
		put_desc(64'h7000, make_attr(1'b1, 1'b0, adma_pkg::ACT_TRAN, w), 64'h7800);
		fill_data(64'h7800, w);
		put_desc(64'h700c, make_attr(1'b0, 1'b1, adma_pkg::ACT_TRAN, 4), 64'h7c00);
		run_table(64'h7000, 0, 1, 1'b0, '0);

		// second start while busy points at the chain table
		w = rand_len();
		put_desc(64'h9000, make_attr(1'b1, 1'b1, adma_pkg::ACT_TRAN, w), 64'ha000);
		fill_data(64'ha000, w);
		run_table(64'h9000, 1, 0, 1'b1, 64'h3000);

		if (dut.u_check.fail_count == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			stop_on_error("protocol assertion failures were recorded");
		end
	end

endmodule

//--- sim.f
source/adma_pkg.sv
source/descriptor_fetch.sv
source/transfer_engine.sv
source/adma_controller.sv
source/adma_top.sv
tests/adma_checker.sv
tests/adma_tb.sv

//--- Makefile
# Verilator simulation of the ADMA descriptor engine

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module adma_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vadma_tb +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
